// ==== logic/knight_pkg.sv ====
// Shared types and tuning constants of the knight command processor, imported by every RTL block.
package knight_pkg;

  ////////////////////
  // Data types
  ////////////////////
  typedef logic [15:0]        cmd_t;        // Opcode in 15:12, heading code in 11:4, squares in 3:0.
  typedef logic signed [11:0] heading_t;    // Gyro heading or heading error.
  typedef logic [9:0]         speed_t;      // Forward speed register.
  typedef logic [3:0]         squares_t;    // Squares to cover in one move.
  typedef logic [4:0]         pulse_cnt_t;  // Line crossings, two per square.

  // Command opcodes, encodings as the Bluetooth host sends them.
  typedef enum logic [3:0] {
    CAL     = 4'b0010,                      // Gyro calibration.
    MOV     = 4'b0100,                      // Plain straight move.
    FANFARE = 4'b0101,                      // Move ending with the charge tune.
    TOUR    = 4'b0110                       // Hand over to the tour solver.
  } opcode_t;

  // Sequencer states.
  typedef enum logic [2:0] {
    IDLE,                                   // Waiting for a command.
    CALIBRATE,                              // Gyro calibrating.
    ALIGN,                                  // Turning onto the commanded heading.
    RAMP_UP,                                // Accelerating and counting squares.
    RAMP_DOWN                               // Braking to a stop.
  } seq_state_t;

  ////////////////////
  // Speed ramp
  ////////////////////
  localparam speed_t SPEED_INC = 10'h020;   // Added per heading update while ramping up.
  localparam speed_t SPEED_DEC = 10'h040;   // Taken off per heading update while braking.
  localparam speed_t SPEED_TOP = 10'h300;   // Both top bits set, cruise speed.

  ////////////////////
  // Heading error
  ////////////////////
  localparam heading_t   NUDGE_LEFT   = 12'h1FF;  // Left IR sees the line, steer right.
  localparam heading_t   NUDGE_RIGHT  = 12'hE00;  // Right IR sees the line, steer left.
  localparam logic [11:0] ALIGN_LIMIT = 12'h02C;  // Error magnitude that counts as aligned.
  localparam logic [3:0] HEADING_FILL = 4'hF;     // Low nibble below a nonzero heading code.

endpackage

// ==== logic/cmd_sequencer.sv ====
// Command FSM of the knight processor; decodes the opcode and steps calibration and moves.
module cmd_sequencer
  import knight_pkg::*;
(
  input  logic clk,                         // System clock.
  input  logic rst_n,                       // Asynchronous reset, active low.
  input  cmd_t cmd,                         // Command word from the host.
  input  logic cmd_rdy,                     // Command valid, held until cleared.
  input  logic cal_done,                    // Gyro calibration finished.
  input  logic aligned,                     // Heading error small enough to drive.
  input  logic move_done,                   // Requested squares covered.
  input  logic speed_zero,                  // Forward speed back at zero.
  output logic clr_cmd_rdy,                 // Command consumed.
  output logic strt_cal,                    // Start gyro calibration.
  output logic tour_go,                     // Start the knight's tour.
  output logic send_resp,                   // Command complete, answer the host.
  output logic fanfare_go,                  // Play the fanfare.
  output logic moving,                      // Robot in motion, gyro integrates yaw.
  output logic start_move,                  // Latch move parameters.
  output logic ramp_clear,                  // Zero the speed register.
  output logic ramp_up,                     // Speed register accelerates.
  output logic ramp_down                    // Speed register brakes.
);

  opcode_t    opcode;                       // Opcode field of the command.
  seq_state_t state;                        // Current state.
  seq_state_t nxt_state;                    // Next state.
  logic       fanfare_q;                    // Move was accepted as FANFARE.

  assign opcode = opcode_t'(cmd[15:12]);    // Top nibble of the command.

  ////////////////////
  // State registers
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;                        // Come out of reset idle.
    end else begin
      state <= nxt_state;
    end
  end

  // Remember the flavour of the move, cmd may change after acceptance.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      fanfare_q <= 1'b0;
    end else if (start_move) begin
      fanfare_q <= (opcode == FANFARE);     // Only FANFARE ends with the tune.
    end
  end

  ////////////////////
  // Next state and outputs
  ////////////////////
  always_comb begin
    nxt_state   = state;                    // Hold by default.
    clr_cmd_rdy = 1'b0;
    strt_cal    = 1'b0;
    tour_go     = 1'b0;
    send_resp   = 1'b0;
    fanfare_go  = 1'b0;
    moving      = 1'b0;
    start_move  = 1'b0;
    ramp_clear  = 1'b0;
    ramp_up     = 1'b0;
    ramp_down   = 1'b0;

    case (state)
      CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;                 // Answer in the same cycle.
          nxt_state = IDLE;
        end
      end

      ALIGN: begin
        moving = 1'b1;                      // Turning in place counts as moving.
        if (aligned) begin
          ramp_clear = 1'b1;                // Start the ramp from standstill.
          nxt_state  = RAMP_UP;
        end
      end

      RAMP_UP: begin
        moving  = 1'b1;
        ramp_up = 1'b1;                     // Accelerate toward cruise speed.
        if (move_done) begin
          fanfare_go = fanfare_q;           // Tune starts as braking begins.
          nxt_state  = RAMP_DOWN;
        end
      end

      RAMP_DOWN: begin
        ramp_down = 1'b1;                   // Brake on each heading update.
        if (speed_zero) begin
          send_resp = 1'b1;                 // Stopped, report the move done.
          nxt_state = IDLE;
        end else begin
          moving = 1'b1;                    // Still rolling.
        end
      end

      default: begin                        // IDLE.
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;               // Every opcode is consumed.
          case (opcode)
            CAL: begin
              strt_cal  = 1'b1;             // Kick the gyro calibration.
              nxt_state = CALIBRATE;
            end
            TOUR: begin
              tour_go = 1'b1;               // Single pulse, no answer follows.
            end
            MOV, FANFARE: begin
              start_move = 1'b1;            // Latch squares and heading.
              nxt_state  = ALIGN;
            end
            default: begin
              nxt_state = IDLE;             // Unknown opcode is dropped.
            end
          endcase
        end
      end
    endcase
  end

  ////////////////////
  // Assertions
  ////////////////////
  a_clr_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    clr_cmd_rdy |-> (state == IDLE))
    else $error("clr_cmd_rdy outside IDLE");

  a_cal_tour_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(strt_cal && tour_go))
    else $error("strt_cal and tour_go together");

  a_resp_fanfare_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(send_resp && fanfare_go))
    else $error("send_resp and fanfare_go together");

endmodule

// ==== logic/speed_ramp.sv ====
// Forward speed register of the knight; ramps up to cruise and brakes to zero per heading update.
module speed_ramp
  import knight_pkg::*;
(
  input  logic   clk,                       // System clock.
  input  logic   rst_n,                     // Asynchronous reset, active low.
  input  logic   heading_rdy,               // New gyro heading, paces the ramp.
  input  logic   ramp_clear,                // Zero the speed.
  input  logic   ramp_up,                   // Accelerate on each update.
  input  logic   ramp_down,                 // Brake on each update.
  output speed_t frwrd,                     // Forward speed to the motor mixer.
  output logic   speed_zero                 // Robot at standstill.
);

  logic at_top;                             // Cruise speed reached.
  logic near_zero;                          // Next brake step would underflow.

  assign at_top     = (frwrd >= SPEED_TOP);
  assign near_zero  = (frwrd < SPEED_DEC);
  assign speed_zero = (frwrd == '0);

  ////////////////////
  // Speed register
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      frwrd <= '0;                          // Stand still after reset.
    end else if (ramp_clear) begin
      frwrd <= '0;                          // New move starts from rest.
    end else if (heading_rdy) begin
      if (ramp_up) begin
        if (!at_top) begin
          frwrd <= frwrd + SPEED_INC;       // Lands exactly on cruise speed.
        end
      end else if (ramp_down) begin
        if (near_zero) begin
          frwrd <= '0;                      // Clamp instead of wrapping.
        end else begin
          frwrd <= frwrd - SPEED_DEC;
        end
      end
    end
  end

  ////////////////////
  // Assertions
  ////////////////////
  // Across the whole ramp, even when braking interrupts mid-step.
  a_speed_cap: assert property (@(posedge clk) disable iff (!rst_n)
    frwrd <= SPEED_TOP)
    else $error("frwrd above SPEED_TOP: %h", frwrd);

endmodule

// ==== logic/square_counter.sv ====
// Counts centre IR line crossings of a move and flags when the requested squares are covered.
module square_counter
  import knight_pkg::*;
(
  input  logic     clk,                     // System clock.
  input  logic     rst_n,                   // Asynchronous reset, active low.
  input  logic     start_move,              // New move accepted.
  input  squares_t cmd_squares,             // Squares requested by the command.
  input  logic     cntr_ir,                 // Centre IR, high over a line.
  output logic     move_done                // Requested distance covered.
);

  logic       cntr_ir_q;                    // Centre IR one cycle back.
  logic       line_rise;                    // Entering a line.
  squares_t   squares;                      // Latched square count.
  pulse_cnt_t pulse_cnt;                    // Crossings seen this move.
  pulse_cnt_t target;                       // Two crossings per square.

  assign line_rise = cntr_ir & ~cntr_ir_q;
  assign target    = {squares, 1'b0};
  assign move_done = (pulse_cnt == target);

  ////////////////////
  // Edge detect and latch
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cntr_ir_q <= 1'b0;
      squares   <= '0;
    end else begin
      cntr_ir_q <= cntr_ir;
      if (start_move) begin
        squares <= cmd_squares;             // Hold the count, cmd may move on.
      end
    end
  end

  ////////////////////
  // Crossing counter
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pulse_cnt <= '0;
    end else if (start_move) begin
      pulse_cnt <= '0;                      // Fresh count per move.
    end else if (line_rise && !move_done) begin
      pulse_cnt <= pulse_cnt + 1'b1;        // Freeze once the target is hit.
    end
  end

  // Braking may roll over another line, the count must stay at the target.
  a_cnt_hold: assert property (@(posedge clk) disable iff (!rst_n)
    move_done && !start_move |=> $stable(pulse_cnt))
    else $error("pulse_cnt passed target: %h", pulse_cnt);

endmodule

// ==== logic/heading_error.sv ====
// Heading error for the PID of the knight; desired-heading latch, IR nudge and alignment test.
module heading_error
  import knight_pkg::*;
(
  input  logic       clk,                   // System clock.
  input  logic       rst_n,                 // Asynchronous reset, active low.
  input  logic       start_move,            // New move accepted.
  input  logic [7:0] cmd_heading,           // Heading code of the command.
  input  heading_t   heading,               // Gyro heading.
  input  logic       lft_ir,                // Left IR over the line.
  input  logic       rght_ir,               // Right IR over the line.
  output heading_t   error,                 // Error term to the PID.
  output logic       aligned                // Error small enough to drive.
);

  heading_t    desired;                     // Commanded heading.
  heading_t    nudge;                       // Line-following correction.
  logic [11:0] error_mag;                   // Magnitude of the error.

  ////////////////////
  // Desired heading
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      desired <= '0;                        // North until the first move.
    end else if (start_move) begin
      if (cmd_heading == 8'h00) begin
        desired <= '0;                      // Code zero is due north.
      end else begin
        desired <= {cmd_heading, HEADING_FILL};
      end
    end
  end

  ////////////////////
  // Error term
  ////////////////////
  // Left IR wins when both see the line.
  always_comb begin
    if (lft_ir) begin
      nudge = NUDGE_LEFT;
    end else if (rght_ir) begin
      nudge = NUDGE_RIGHT;
    end else begin
      nudge = '0;
    end
  end

  assign error = heading - desired + nudge; // Wraps like the gyro heading.

  // Unsigned magnitude, so the most negative error reads as large.
  assign error_mag = error[11] ? 12'(-error) : 12'(error);
  assign aligned   = (error_mag < ALIGN_LIMIT);

endmodule

// ==== logic/cmd_proc.sv ====
// Top of the knight command processor; connects the sequencer, speed ramp, counter and error.
module cmd_proc
  import knight_pkg::*;
(
  input  logic     clk,                     // System clock.
  input  logic     rst_n,                   // Asynchronous reset, active low.
  input  cmd_t     cmd,                     // Command word from the host.
  input  logic     cmd_rdy,                 // Command valid.
  output logic     clr_cmd_rdy,             // Command consumed.
  output logic     send_resp,               // Command complete.
  output logic     strt_cal,                // Start gyro calibration.
  input  logic     cal_done,                // Gyro calibration finished.
  input  heading_t heading,                 // Gyro heading.
  input  logic     heading_rdy,             // Heading valid for one cycle.
  input  logic     lft_ir,                  // Left IR.
  input  logic     cntr_ir,                 // Centre IR.
  input  logic     rght_ir,                 // Right IR.
  output heading_t error,                   // Error term to the PID.
  output speed_t   frwrd,                   // Forward speed.
  output logic     moving,                  // Robot in motion.
  output logic     tour_go,                 // Start the knight's tour.
  output logic     fanfare_go               // Play the fanfare.
);

  logic start_move;                         // Move accepted.
  logic ramp_clear;                         // Zero the speed.
  logic ramp_up;                            // Accelerate.
  logic ramp_down;                          // Brake.
  logic speed_zero;                         // Standstill.
  logic move_done;                          // Squares covered.
  logic aligned;                            // On heading.

  ////////////////////
  // Blocks
  ////////////////////
  cmd_sequencer i_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .cmd_rdy    (cmd_rdy),
    .cal_done   (cal_done),
    .aligned    (aligned),
    .move_done  (move_done),
    .speed_zero (speed_zero),
    .clr_cmd_rdy(clr_cmd_rdy),
    .strt_cal   (strt_cal),
    .tour_go    (tour_go),
    .send_resp  (send_resp),
    .fanfare_go (fanfare_go),
    .moving     (moving),
    .start_move (start_move),
    .ramp_clear (ramp_clear),
    .ramp_up    (ramp_up),
    .ramp_down  (ramp_down)
  );

  speed_ramp i_ramp (
    .clk        (clk),
    .rst_n      (rst_n),
    .heading_rdy(heading_rdy),
    .ramp_clear (ramp_clear),
    .ramp_up    (ramp_up),
    .ramp_down  (ramp_down),
    .frwrd      (frwrd),
    .speed_zero (speed_zero)
  );

  square_counter i_squares (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_move (start_move),
    .cmd_squares(cmd[3:0]),                 // Square count field.
    .cntr_ir    (cntr_ir),
    .move_done  (move_done)
  );

  heading_error i_err (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_move (start_move),
    .cmd_heading(cmd[11:4]),                // Heading code field.
    .heading    (heading),
    .lft_ir     (lft_ir),
    .rght_ir    (rght_ir),
    .error      (error),
    .aligned    (aligned)
  );

endmodule

// ==== bench/cmd_proc_checks.sv ====
// Checker for the knight command processor; holds reference models and concurrent assertions.
module cmd_proc_checks
  import knight_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input cmd_t     cmd,
  input logic     cmd_rdy,
  input logic     clr_cmd_rdy,
  input logic     send_resp,
  input logic     strt_cal,
  input logic     cal_done,
  input heading_t heading,
  input logic     heading_rdy,
  input logic     lft_ir,
  input logic     cntr_ir,
  input logic     rght_ir,
  input heading_t error,
  input speed_t   frwrd,
  input logic     moving,
  input logic     tour_go,
  input logic     fanfare_go
);
  timeunit 1ns;
  timeprecision 100ps;

  int         fail_cnt = 0;                 // Failed checks so far.
  logic       seen_cmd;                     // First command has arrived.
  logic       in_cal;                       // Calibration running.
  logic       in_move;                      // Move running.
  logic       fan_q;                        // Current move is FANFARE.
  logic       was_aligned;                  // Model saw alignment this move.
  logic       ir_q;                         // Centre IR one cycle back.
  logic [5:0] edge_cnt;                     // Line entries this move.
  logic [5:0] target;                       // Two entries per square.
  int         fan_cnt;                      // Fanfare pulses this move.
  heading_t   des;                          // Commanded heading.
  heading_t   nudge;                        // IR correction.
  heading_t   exp_err;                      // Expected error term.
  logic [3:0] op;                           // Opcode of the offered command.
  logic       is_move;                      // Offered command is a move.

  assign op      = cmd[15:12];
  assign is_move = (op == MOV) || (op == FANFARE);
  assign nudge   = lft_ir ? NUDGE_LEFT : (rght_ir ? NUDGE_RIGHT : heading_t'(0));
  assign exp_err = heading - des + nudge;

  // Print one failed check and count it.
  task automatic count_fail(input string msg);
    $display("%s", msg);
    fail_cnt++;
  endtask

  ////////////////////
  // Reference state
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      seen_cmd <= 1'b0;
      in_cal <= 1'b0;
      in_move <= 1'b0;
      fan_q <= 1'b0;
      was_aligned <= 1'b0;
      ir_q <= 1'b0;
      edge_cnt <= '0;
      target <= '0;
      fan_cnt <= 0;
      des <= '0;
    end else begin
      ir_q <= cntr_ir;
      if (cmd_rdy) seen_cmd <= 1'b1;
      if (strt_cal) in_cal <= 1'b1;         // Calibration in progress.
      if (send_resp) begin
        in_cal <= 1'b0;
        in_move <= 1'b0;
      end
      if (cntr_ir && !ir_q) edge_cnt <= edge_cnt + 1'b1;
      if (fanfare_go) fan_cnt <= fan_cnt + 1;
      if (in_move && (exp_err < heading_t'(ALIGN_LIMIT))
          && (exp_err > -heading_t'(ALIGN_LIMIT)))
        was_aligned <= 1'b1;
      if (clr_cmd_rdy && is_move) begin
        in_move <= 1'b1;                    // New move, fresh model.
        fan_q <= (op == FANFARE);
        was_aligned <= 1'b0;
        edge_cnt <= '0;
        fan_cnt <= 0;
        target <= {1'b0, cmd[3:0], 1'b0};
        des <= (cmd[11:4] == 8'h00) ? heading_t'(0) : {cmd[11:4], 4'hF};
      end
    end
  end

  ////////////////////
  // Assertions
  ////////////////////
  c_reset: assert property (@(posedge clk) disable iff (!rst_n)
    !(seen_cmd || cmd_rdy)
      |-> !(clr_cmd_rdy | send_resp | strt_cal | tour_go | fanfare_go | moving) && frwrd == '0)
    else count_fail("Outputs active before the first command");
  c_cal: assert property (@(posedge clk) disable iff (!rst_n)
    (clr_cmd_rdy && op == CAL) == strt_cal)
    else count_fail($sformatf("[FAIL] strt_cal exp %h got %h",
                              clr_cmd_rdy && op == CAL, strt_cal));
  c_resp_cal: assert property (@(posedge clk) disable iff (!rst_n)
    in_cal |-> send_resp == cal_done)
    else count_fail($sformatf("[FAIL] send_resp exp %h got %h", cal_done, send_resp));
  c_tour: assert property (@(posedge clk) disable iff (!rst_n)
    (clr_cmd_rdy && op == TOUR) == tour_go)
    else count_fail($sformatf("[FAIL] tour_go exp %h got %h",
                              clr_cmd_rdy && op == TOUR, tour_go));
  c_resp_src: assert property (@(posedge clk) disable iff (!rst_n)
    send_resp |-> in_cal || in_move)
    else count_fail("Response without a pending command");
  c_error: assert property (@(posedge clk) disable iff (!rst_n)
    moving |-> error == exp_err)
    else count_fail($sformatf("[FAIL] error exp %h got %h", exp_err, error));
  // Low only in the stop cycle of a move.
  c_moving: assert property (@(posedge clk) disable iff (!rst_n)
    moving == (in_move && !send_resp))
    else count_fail($sformatf("[FAIL] moving exp %h got %h", in_move && !send_resp, moving));
  c_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    in_move && frwrd != '0 |-> was_aligned)
    else count_fail("Ramp started before alignment");
  c_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !heading_rdy |=> $stable(frwrd))
    else count_fail($sformatf("[FAIL] frwrd exp %h got %h", $past(frwrd), frwrd));
  c_step: assert property (@(posedge clk) disable iff (!rst_n)
    heading_rdy |=> frwrd == $past(frwrd) || frwrd == '0
      || speed_t'(frwrd - $past(frwrd)) == SPEED_INC
      || speed_t'($past(frwrd) - frwrd) == SPEED_DEC)
    else count_fail($sformatf("[FAIL] frwrd step from %h got %h", $past(frwrd), frwrd));
  c_top: assert property (@(posedge clk) disable iff (!rst_n)
    frwrd <= SPEED_TOP)
    else count_fail($sformatf("[FAIL] frwrd max %h got %h", SPEED_TOP, frwrd));
  c_no_early_brake: assert property (@(posedge clk) disable iff (!rst_n)
    heading_rdy && edge_cnt < target |=> frwrd >= $past(frwrd))
    else count_fail("Braking before all squares were crossed");
  c_resp_move: assert property (@(posedge clk) disable iff (!rst_n)
    send_resp && in_move |-> frwrd == '0 && edge_cnt >= target)
    else count_fail($sformatf("[FAIL] frwrd exp %h got %h, edge_cnt %h target %h",
                              10'h000, frwrd, edge_cnt, target));
  c_fanfare: assert property (@(posedge clk) disable iff (!rst_n)
    fanfare_go |-> in_move && fan_q && fan_cnt == 0 && edge_cnt >= target)
    else count_fail("Unexpected fanfare_go pulse");
  c_fan_once: assert property (@(posedge clk) disable iff (!rst_n)
    send_resp && in_move && fan_q |-> fan_cnt == 1)
    else count_fail($sformatf("[FAIL] fanfare count exp %h got %h", 1, fan_cnt));

endmodule

// ==== bench/cmd_proc_tb.sv ====
// Testbench of the knight command processor; drives commands, gyro and IR, reports per test.
module cmd_proc_tb
  import knight_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  logic     clk;
  logic     rst_n;
  cmd_t     cmd;
  logic     cmd_rdy;
  logic     cal_done;
  heading_t heading;
  logic     heading_rdy;
  logic     lft_ir;
  logic     cntr_ir;
  logic     rght_ir;
  logic     clr_cmd_rdy;
  logic     send_resp;
  logic     strt_cal;
  logic     moving;
  logic     tour_go;
  logic     fanfare_go;
  heading_t error;
  speed_t   frwrd;
  integer   seed = 38197;                   // Fixed seed for the gyro heading.
  int       timeouts = 0;                   // Waits that ran out.
  int       tests = 0;                      // Tests finished.
  int       last_fails = 0;                 // Failures before the current test.

  cmd_proc i_dut (.*);
  cmd_proc_checks i_chk (.*);

  always #4 clk = ~clk;                     // 8 ns period.

  // Offer a command and hold it until the DUT takes it.
  task automatic send_cmd(input cmd_t c);
    int n;
    @(posedge clk) #1;
    cmd = c;
    cmd_rdy = 1'b1;
    for (n = 0; n < 50 && !clr_cmd_rdy; n++) @(negedge clk);
    if (!clr_cmd_rdy) begin
      $display("Timeout waiting for clr_cmd_rdy");
      timeouts++;
    end
    @(posedge clk) #1;
    cmd_rdy = 1'b0;
    cmd = cmd_t'($random(seed));            // DUT must not look again.
  endtask

  task automatic finish_test(input string name);
    int fails;
    fails = i_chk.fail_cnt + timeouts;
    tests++;
    $display("test %-8s %s", name, (fails == last_fails) ? "ok" : "failed");
    last_fails = fails;
  endtask

  // Run one move: misaligned gyro first, then aligned, lines and IR nudges.
  task automatic run_move(input logic [3:0] op, input logic [7:0] code, input squares_t n);
    heading_t des;
    int cyc;
    des = (code == 8'h00) ? heading_t'(0) : {code, HEADING_FILL};
    send_cmd({op, code, n});
    for (cyc = 0; cyc < 3000 && !send_resp; cyc++) begin
      @(posedge clk) #1;
      heading_rdy = (cyc % 3 == 0);
      if (cyc < 6) heading = heading_t'($random(seed));
      else heading = des + heading_t'($random(seed) % 16);
      cntr_ir = (cyc >= 10) && (cyc % 10 >= 6);
      lft_ir  = (cyc >= 12) && ($random(seed) % 7 == 0);
      rght_ir = (cyc >= 12) && ($random(seed) % 5 == 0);
      @(negedge clk);
    end
    if (!send_resp) begin
      $display("Timeout waiting for the end of the move");
      timeouts++;
    end
    @(posedge clk) #1;
    heading_rdy = 1'b0;
    {cntr_ir, lft_ir, rght_ir} = '0;
  endtask

  initial begin
    int n;
    clk = 1'b0;
    rst_n = 1'b0;
    cmd = '0;
    cmd_rdy = 1'b0;
    cal_done = 1'b0;
    heading = '0;
    heading_rdy = 1'b0;
    {lft_ir, cntr_ir, rght_ir} = '0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (10) @(posedge clk);              // Idle outputs watched by the checker.
    finish_test("reset");

    send_cmd({CAL, 12'h000});
    repeat (5) @(posedge clk);
    #1 cal_done = 1'b1;
    for (n = 0; n < 20 && !send_resp; n++) @(negedge clk);
    if (!send_resp) begin
      $display("Timeout waiting for the calibration response");
      timeouts++;
    end
    @(posedge clk) #1 cal_done = 1'b0;
    finish_test("cal");

    send_cmd({TOUR, 12'h000});
    repeat (20) @(posedge clk);              // Window in which no response may come.
    finish_test("tour");

    run_move(MOV, 8'h00, 4'd1);
    finish_test("mov1");
    run_move(MOV, 8'h3F, 4'd5);              // Long enough to reach cruise speed.
    finish_test("mov2");
    run_move(FANFARE, 8'h7F, 4'd3);
    finish_test("fanfare");
    repeat (5) @(posedge clk);

    $display("tests %0d, failed checks %0d, timeouts %0d", tests, i_chk.fail_cnt, timeouts);
    if (i_chk.fail_cnt == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
logic/knight_pkg.sv
logic/cmd_sequencer.sv
logic/speed_ramp.sv
logic/square_counter.sv
logic/heading_error.sv
logic/cmd_proc.sv
bench/cmd_proc_checks.sv
bench/cmd_proc_tb.sv

// ==== Makefile ====
# Verilator flow for the knight command processor.

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module cmd_proc_tb -f tb.f

sim:
	verilator --binary --timing --assert --top-module cmd_proc_tb -f tb.f -o cmd_proc_sim
	./obj_dir/cmd_proc_sim | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
